// ==== apb_debug_port.sv ====
`timescale 1ns/1ps

module apb_debug_port (
    input  logic                clk, reset, psel, penable, pwrite, halt_retired,
    input  core_pkg::apb_addr_t paddr,
    input  core_pkg::word_t     pwdata, dbg_idata, dbg_rdata,
    output core_pkg::word_t     prdata, dbg_wdata,
    output core_pkg::apb_addr_t dbg_addr,
    output logic                pready, pslverr, run, dbg_imem_we, dbg_dmem_we
);
    import core_pkg::*;

    logic access;
    logic sel_ctrl;
    logic sel_imem;
    logic sel_dmem;
    logic err;

    assign access   = psel && penable;
    assign sel_ctrl = paddr == ctrl_addr;
    assign sel_imem = paddr[15:12] == imem_base[15:12];
    assign sel_dmem = paddr[15:12] == dmem_base[15:12];

    // unmapped, or memory touched while running
    assign err = !(sel_ctrl || sel_imem || sel_dmem) || ((sel_imem || sel_dmem) && run);

    assign pready      = 1'b1;
    assign pslverr     = access && err;
    assign dbg_addr    = paddr;
    assign dbg_wdata   = pwdata;
    assign dbg_imem_we = access && pwrite && sel_imem && !run;
    assign dbg_dmem_we = access && pwrite && sel_dmem && !run;

    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata = {31'b0, run};
        end else if (!err && sel_imem) begin
            prdata = dbg_idata;
        end else if (!err && sel_dmem) begin
            prdata = dbg_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else if (access && pwrite && sel_ctrl && pwdata[0] && !run) begin
            run <= 1'b1;
        end else if (halt_retired) begin
            run <= 1'b0;
        end
    end

endmodule

// ==== core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] apb_addr_t;

    // bit 0 write starts the core, read returns run
    localparam apb_addr_t ctrl_addr = 16'h0000;

    // 4 KiB windows, word aligned
    localparam apb_addr_t imem_base = 16'h1000;
    localparam apb_addr_t dmem_base = 16'h2000;

endpackage

// ==== cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int dmem_words = 256;
    localparam int max_steps = 200;
    localparam int num_programs = 25;
    // imem loads, dmem load and readback, and run polls
    localparam int apb_per_prog = 100 + 2 * dmem_words + max_steps;
    localparam int watchdog_cycles = num_programs * (3 * max_steps + 3 * apb_per_prog) + 100;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      psel = 1'b0;
    logic      penable = 1'b0;
    logic      pwrite = 1'b0;
    apb_addr_t paddr = '0;
    word_t     pwdata = '0;
    word_t     prdata;
    logic      pready, pslverr;

    word_t prog [$];
    word_t exp_dmem [dmem_words];
    int    salt = 0;

    cpu_top cpu_top_i (.*);

    always #2 clk = ~clk;

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the core or a bus access did not finish in %0d cycles",
                 watchdog_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "bit compare failed");
        end
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
                              output word_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        // outputs settle during the access phase
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_bit(pready, 1'b1, "pready");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic apb_addr_t word_addr(input apb_addr_t base, input int idx);
        return base + apb_addr_t'(4 * idx);
    endfunction

    function automatic word_t fill_word(input int idx);
        return (32'h9e3779b9 * word_t'(idx + 1)) ^ {8'(salt), 8'(idx), 16'(idx * 3)};
    endfunction

    function automatic word_t enc_r(input funct_t fn, input int rd, input int rs, input int rt);
        return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input int rt, input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // ISA-level interpreter, returns steps to halt or -1
    function automatic int reference_run();
        word_t r [32];
        word_t pc;
        word_t nxt;
        word_t ins;
        word_t imm;
        word_t val;
        for (int i = 0; i < 32; i++) r[i] = '0;
        pc = '0;
        for (int steps = 1; steps <= max_steps; steps++) begin
            ins = prog[pc[9:2]];
            imm = {{16{ins[15]}}, ins[15:0]};
            nxt = pc + 32'd4;
            case (ins[31:26])
                6'h00: begin
                    case (ins[5:0])
                        6'h20: val = r[ins[25:21]] + r[ins[20:16]];
                        6'h22: val = r[ins[25:21]] - r[ins[20:16]];
                        6'h24: val = r[ins[25:21]] & r[ins[20:16]];
                        6'h25: val = r[ins[25:21]] | r[ins[20:16]];
                        default: val = {31'b0, $signed(r[ins[25:21]]) < $signed(r[ins[20:16]])};
                    endcase
                    if (ins[15:11] != 5'd0) r[ins[15:11]] = val;
                end
                6'h08: if (ins[20:16] != 5'd0) r[ins[20:16]] = r[ins[25:21]] + imm;
                6'h23: begin
                    val = r[ins[25:21]] + imm;
                    if (ins[20:16] != 5'd0) r[ins[20:16]] = exp_dmem[val[9:2]];
                end
                6'h2b: begin
                    val = r[ins[25:21]] + imm;
                    exp_dmem[val[9:2]] = r[ins[20:16]];
                end
                6'h04: if (r[ins[25:21]] == r[ins[20:16]]) nxt = pc + 32'd4 + (imm << 2);
                6'h02: nxt = {nxt[31:28], ins[25:0], 2'b00};
                6'h3f: return steps;
                default: ;
            endcase
            pc = nxt;
        end
        return -1;
    endfunction

    task automatic load_program();
        word_t rd;
        logic  err;
        salt++;
        foreach (prog[i]) begin
            apb_access(1'b1, word_addr(imem_base, i), prog[i], rd, err);
            check_bit(err, 1'b0, "pslverr imem load");
        end
        for (int i = 0; i < dmem_words; i++) begin
            exp_dmem[i] = fill_word(i);
            apb_access(1'b1, word_addr(dmem_base, i), fill_word(i), rd, err);
            check_bit(err, 1'b0, "pslverr dmem load");
        end
        if (reference_run() < 0) begin
            $display("Reference interpreter did not reach a halt instruction");
            $display("SOME TESTS FAILED");
            $fatal(1, "bad program");
        end
    endtask

    task automatic wait_halt();
        word_t rd;
        logic  err;
        do begin
            apb_access(1'b0, ctrl_addr, '0, rd, err);
            check_bit(err, 1'b0, "pslverr ctrl poll");
        end while (rd[0]);
    endtask

    task automatic compare_dmem();
        word_t rd;
        logic  err;
        for (int i = 0; i < dmem_words; i++) begin
            apb_access(1'b0, word_addr(dmem_base, i), '0, rd, err);
            check_bit(err, 1'b0, "pslverr dmem read");
            check_word(rd, exp_dmem[i], $sformatf("dmem[%0d]", i));
        end
    endtask

    task automatic run_program();
        word_t rd;
        logic  err;
        load_program();
        apb_access(1'b1, ctrl_addr, 32'd1, rd, err);
        wait_halt();
        compare_dmem();
    endtask

    function automatic int rand_reg();
        return int'($urandom % 32);
    endfunction

    initial begin
        word_t rd;
        logic  err;
        int    kind;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        void'($urandom(32'h6313));

        // control and error responses
        apb_access(1'b0, ctrl_addr, '0, rd, err);
        check_word(rd, 32'd0, "ctrl after reset");
        check_bit(err, 1'b0, "pslverr after reset");
        apb_access(1'b0, 16'h3000, '0, rd, err);
        check_bit(err, 1'b1, "pslverr unmapped read");
        apb_access(1'b1, 16'h0004, 32'd1, rd, err);
        check_bit(err, 1'b1, "pslverr unmapped write");
        prog.delete();
        // register file has no reset
        prog.push_back(enc_i(op_addi, 1, 0, 0));
        for (int i = 0; i < 40; i++) prog.push_back(enc_i(op_addi, 1, 1, 1));
        prog.push_back(enc_i(op_sw, 1, 0, 64));
        prog.push_back({op_halt, 26'b0});
        load_program();
        apb_access(1'b1, ctrl_addr, 32'd1, rd, err);
        apb_access(1'b1, imem_base, 32'hdeadbeef, rd, err);
        check_bit(err, 1'b1, "pslverr imem write while running");
        apb_access(1'b0, dmem_base, '0, rd, err);
        check_bit(err, 1'b1, "pslverr dmem read while running");
        wait_halt();
        apb_access(1'b0, imem_base, '0, rd, err);
        check_word(rd, prog[0], "imem[0] after blocked write");
        compare_dmem();

        // dependent alu chains
        prog = '{enc_i(op_addi, 1, 0, 5), enc_i(op_addi, 2, 1, 7),
                 enc_r(fn_add, 3, 1, 2), enc_r(fn_sub, 4, 3, 1),
                 enc_r(fn_and, 5, 4, 3), enc_r(fn_or, 6, 5, 2),
                 enc_r(fn_slt, 7, 4, 3), enc_r(fn_slt, 8, 3, 4),
                 enc_i(op_addi, 9, 0, -3), enc_r(fn_slt, 10, 9, 1),
                 enc_r(fn_sub, 11, 9, 6), enc_i(op_addi, 12, 11, 100)};
        for (int i = 1; i <= 12; i++) prog.push_back(enc_i(op_sw, i, 0, 256 + 4 * i));
        prog.push_back({op_halt, 26'b0});
        run_program();

        // load-use
        prog = '{enc_i(op_lw, 1, 0, 0), enc_i(op_addi, 2, 1, 1),
                 enc_i(op_lw, 3, 0, 4), enc_i(op_sw, 3, 0, 8),
                 enc_i(op_lw, 4, 0, 12), enc_r(fn_add, 5, 4, 4),
                 enc_i(op_sw, 5, 0, 16), enc_i(op_sw, 2, 0, 20),
                 {op_halt, 26'b0}};
        run_program();

        // taken beq, not-taken beq, j
        prog = '{enc_i(op_addi, 1, 0, 3), enc_i(op_addi, 2, 0, 3),
                 enc_i(op_beq, 2, 1, 2), enc_i(op_sw, 1, 0, 64),
                 enc_i(op_sw, 2, 0, 68), enc_i(op_addi, 3, 0, 9),
                 enc_i(op_beq, 3, 1, 1), enc_i(op_sw, 3, 0, 72),
                 {op_j, 26'd11}, enc_i(op_sw, 3, 0, 76),
                 enc_i(op_sw, 3, 0, 80), enc_i(op_sw, 1, 0, 84),
                 {op_halt, 26'b0}};
        run_program();

        // random straight-line programs
        for (int p = 0; p < 20; p++) begin
            prog.delete();
            for (int i = 1; i < 32; i++) prog.push_back(enc_i(op_addi, i, 0, int'($urandom)));
            for (int k = 0; k < 30; k++) begin
                kind = int'($urandom % 7);
                case (kind)
                    0: prog.push_back(enc_r(fn_add, rand_reg(), rand_reg(), rand_reg()));
                    1: prog.push_back(enc_r(fn_sub, rand_reg(), rand_reg(), rand_reg()));
                    2: prog.push_back(enc_r(fn_and, rand_reg(), rand_reg(), rand_reg()));
                    3: prog.push_back(enc_r(fn_or, rand_reg(), rand_reg(), rand_reg()));
                    4: prog.push_back(enc_r(fn_slt, rand_reg(), rand_reg(), rand_reg()));
                    5: prog.push_back(enc_i(op_addi, rand_reg(), rand_reg(), int'($urandom)));
                    default: prog.push_back(enc_i(op_lw, rand_reg(), 0, 4 * int'($urandom % 256)));
                endcase
            end
            for (int i = 0; i < 32; i++) prog.push_back(enc_i(op_sw, i, 0, 4 * i));
            prog.push_back({op_halt, 26'b0});
            run_program();
            apb_access(1'b0, dmem_base, '0, rd, err);
            check_word(rd, 32'd0, "stored r0");
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int imem_depth = 256,
    parameter int dmem_depth = 256
) (
    input  logic                clk, reset,
    input  logic                psel, penable, pwrite,
    input  core_pkg::apb_addr_t paddr,
    input  core_pkg::word_t     pwdata,
    output core_pkg::word_t     prdata,
    output logic                pready, pslverr
);
    import core_pkg::*;
    import isa_pkg::*;

    // run control and debug access
    logic      run, halt_retired, dbg_imem_we, dbg_dmem_we;
    apb_addr_t dbg_addr;
    word_t     dbg_wdata, dbg_idata, dbg_rdata;

    // if/id
    logic  if_valid;
    word_t if_pc, if_instr;

    // hazards and redirects
    logic  stall, halt_seen, redirect, flush;
    word_t redirect_pc;

    // id/ex
    logic     ex_valid, ex_mem_read, ex_mem_write, ex_reg_write;
    logic     ex_branch, ex_jump, ex_use_imm, ex_halt;
    alu_op_t  ex_alu_op;
    word_t    ex_pc, ex_rs_data, ex_rt_data, ex_imm, ex_target;
    reg_idx_t ex_rs, ex_rt, ex_rd;

    // ex/mem
    logic     mem_valid, mem_read, mem_write, mem_reg_write, mem_halt;
    word_t    mem_result, mem_store_data;
    reg_idx_t mem_dest;

    // write-back
    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;

    fetch_stage #(
        .imem_depth (imem_depth)
    ) fetch_stage_i (.*);

    decode_stage decode_stage_i (.*);

    execute_stage execute_stage_i (.*);

    memory_stage #(
        .dmem_depth (dmem_depth)
    ) memory_stage_i (.*);

    apb_debug_port apb_debug_port_i (.*);

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk, reset, if_valid, flush, wb_en,
    input  core_pkg::word_t    if_pc, if_instr, wb_data,
    input  core_pkg::reg_idx_t wb_idx,
    output logic               stall, halt_seen, ex_valid, ex_mem_read, ex_mem_write,
    output logic               ex_reg_write, ex_branch, ex_jump, ex_use_imm, ex_halt,
    output isa_pkg::alu_op_t   ex_alu_op,
    output core_pkg::word_t    ex_pc, ex_rs_data, ex_rt_data, ex_imm, ex_target,
    output core_pkg::reg_idx_t ex_rs, ex_rt, ex_rd
);
    import core_pkg::*;
    import isa_pkg::*;

    instr_t   instr;
    word_t    regs [32];
    word_t    rs_val, rt_val;
    word_t    pc_plus4;
    reg_idx_t dest;
    alu_op_t  alu_op;
    logic     reg_write, mem_read, mem_write, branch, jump, use_imm, halt;
    logic     uses_rs, uses_rt;
    logic     bubble;

    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        // same-cycle write-back
        if (wb_en && wb_idx == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    assign instr    = if_instr;
    assign pc_plus4 = if_pc + 32'd4;

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        use_imm   = 1'b0;
        halt      = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        alu_op    = alu_add;
        dest      = instr.r.rd;
        case (instr.r.opcode)
            op_rtype: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (instr.r.funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: reg_write = 1'b0;
                endcase
            end
            op_addi, op_lw: begin
                uses_rs   = 1'b1;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = instr.i.opcode == op_lw;
                dest      = instr.i.rt;
            end
            op_sw: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            op_beq: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                branch  = 1'b1;
            end
            op_j:    jump = 1'b1;
            op_halt: halt = 1'b1;
            default: ;
        endcase
        // r0 writes are dropped here
        if (dest == '0) begin
            reg_write = 1'b0;
        end
        rs_val = read_reg(instr.i.rs);
        rt_val = read_reg(instr.i.rt);
    end

    // load in ex feeding this instruction
    assign stall = if_valid && ex_valid && ex_mem_read && ex_reg_write &&
                   ((uses_rs && ex_rd == instr.i.rs) || (uses_rt && ex_rd == instr.i.rt));
    assign halt_seen = if_valid && !flush && halt;
    assign bubble    = !if_valid || stall || flush;

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
            ex_use_imm   <= 1'b0;
            ex_halt      <= 1'b0;
        end else begin
            ex_valid     <= !bubble;
            ex_mem_read  <= !bubble && mem_read;
            ex_mem_write <= !bubble && mem_write;
            ex_reg_write <= !bubble && reg_write;
            ex_branch    <= !bubble && branch;
            ex_jump      <= !bubble && jump;
            ex_use_imm   <= !bubble && use_imm;
            ex_halt      <= !bubble && halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op  <= alu_op;
        ex_pc      <= if_pc;
        ex_rs_data <= rs_val;
        ex_rt_data <= rt_val;
        ex_imm     <= {{16{instr.i.imm[15]}}, instr.i.imm};
        ex_target  <= {pc_plus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};
        ex_rs      <= instr.i.rs;
        ex_rt      <= instr.i.rt;
        ex_rd      <= dest;
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk, reset,
    input  logic               ex_valid, ex_mem_read, ex_mem_write, ex_reg_write,
    input  logic               ex_branch, ex_jump, ex_use_imm, ex_halt,
    input  isa_pkg::alu_op_t   ex_alu_op,
    input  core_pkg::word_t    ex_pc, ex_rs_data, ex_rt_data, ex_imm, ex_target,
    input  core_pkg::reg_idx_t ex_rs, ex_rt, ex_rd,
    input  logic               wb_en,
    input  core_pkg::reg_idx_t wb_idx,
    input  core_pkg::word_t    wb_data,
    output logic               redirect, flush, mem_valid, mem_read, mem_write,
    output logic               mem_reg_write, mem_halt,
    output core_pkg::word_t    redirect_pc, mem_result, mem_store_data,
    output core_pkg::reg_idx_t mem_dest
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t op_a;
    word_t rt_fwd;
    word_t op_b;
    word_t alu_out;
    logic  taken;

    // younger producer first; a load in ex/mem never feeds ex after the stall
    function automatic word_t forward(input reg_idx_t idx, input word_t reg_val);
        if (mem_valid && mem_reg_write && !mem_read && mem_dest == idx) begin
            return mem_result;
        end
        if (wb_en && wb_idx == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a   = forward(ex_rs, ex_rs_data);
        rt_fwd = forward(ex_rt, ex_rt_data);
        op_b   = ex_use_imm ? ex_imm : rt_fwd;
        case (ex_alu_op)
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    assign taken       = ex_valid && (ex_jump || (ex_branch && op_a == rt_fwd));
    assign redirect    = taken;
    assign flush       = taken;
    assign redirect_pc = ex_jump ? ex_target : ex_pc + 32'd4 + {ex_imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid     <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_halt      <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
            mem_halt      <= ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= alu_out;
        mem_store_data <= rt_fwd;
        mem_dest       <= ex_rd;
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter int imem_depth = 256
) (
    input  logic                clk, reset, run, stall, redirect, halt_seen, dbg_imem_we,
    input  core_pkg::word_t     redirect_pc, dbg_wdata,
    input  core_pkg::apb_addr_t dbg_addr,
    output logic                if_valid,
    output core_pkg::word_t     if_pc, if_instr, dbg_idata
);
    import core_pkg::*;

    localparam int idx_w = $clog2(imem_depth);

    word_t            imem [imem_depth];
    word_t            pc;
    word_t            pc_cur;
    logic             run_q;
    logic             halted;
    logic             start;
    logic             issue;
    logic [idx_w-1:0] fetch_idx;
    logic [idx_w-1:0] dbg_idx;

    // rising edge of run restarts at address zero
    assign start     = run && !run_q;
    assign pc_cur    = start ? '0 : pc;
    assign issue     = run && (start || !halted) && !halt_seen;
    assign fetch_idx = pc_cur[idx_w+1:2];
    assign dbg_idx   = dbg_addr[idx_w+1:2];
    assign dbg_idata = imem[dbg_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q    <= 1'b0;
            halted   <= 1'b0;
            pc       <= '0;
            if_valid <= 1'b0;
        end else begin
            run_q <= run;
            if (halt_seen) begin
                halted <= 1'b1;
            end else if (start) begin
                halted <= 1'b0;
            end
            // redirect wins over stall
            if (redirect) begin
                pc <= redirect_pc;
            end else if (issue && !stall) begin
                pc <= pc_cur + 32'd4;
            end
            if (redirect || halt_seen) begin
                if_valid <= 1'b0;
            end else if (!stall) begin
                if_valid <= issue;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc    <= pc_cur;
            if_instr <= imem[fetch_idx];
        end
        if (dbg_imem_we) begin
            imem[dbg_idx] <= dbg_wdata;
        end
    end

endmodule

// ==== files.f ====
core_pkg.sv
isa_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
apb_debug_port.sv
cpu_top.sv
cpu_tb.sv

// ==== isa_pkg.sv ====
package isa_pkg;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b,
        op_halt  = 6'h3f
    } opcode_t;

    // r-type function codes
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_t      funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // same word, two views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

endpackage

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage #(
    parameter int dmem_depth = 256
) (
    input  logic                clk, reset, mem_valid, mem_read, mem_write,
    input  logic                mem_reg_write, mem_halt, dbg_dmem_we,
    input  core_pkg::word_t     mem_result, mem_store_data, dbg_wdata,
    input  core_pkg::reg_idx_t  mem_dest,
    input  core_pkg::apb_addr_t dbg_addr,
    output logic                wb_en, halt_retired,
    output core_pkg::reg_idx_t  wb_idx,
    output core_pkg::word_t     wb_data, dbg_rdata
);
    import core_pkg::*;

    localparam int idx_w = $clog2(dmem_depth);

    word_t            dmem [dmem_depth];
    logic [idx_w-1:0] data_idx;
    logic [idx_w-1:0] dbg_idx;
    logic             wb_load;
    word_t            wb_result;
    word_t            wb_mem_data;

    assign data_idx  = mem_result[idx_w+1:2];
    assign dbg_idx   = dbg_addr[idx_w+1:2];
    assign dbg_rdata = dmem[dbg_idx];

    // debug writes only happen while halted
    always_ff @(posedge clk) begin
        if (mem_valid && mem_write) begin
            dmem[data_idx] <= mem_store_data;
        end else if (dbg_dmem_we) begin
            dmem[dbg_idx] <= dbg_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en        <= 1'b0;
            halt_retired <= 1'b0;
        end else begin
            wb_en        <= mem_valid && mem_reg_write;
            halt_retired <= mem_valid && mem_halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_load     <= mem_read;
        wb_result   <= mem_result;
        wb_mem_data <= dmem[data_idx];
        wb_idx      <= mem_dest;
    end

    assign wb_data = wb_load ? wb_mem_data : wb_result;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f files.f --top-module cpu_tb
./obj_dir/Vcpu_tb 2>&1 | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    exit 1
fi
exit 0
